// File: common/slap_video_pkg.sv
// shared video widths, register map, pixel code union and palette table selectors

package slap_video_pkg;

	// ==============================
	// widths and coordinate types
	// ==============================
	localparam int H_POS_W  = 9;
	localparam int V_POS_W  = 8;
	localparam int COLOUR_W = 4;
	localparam int DL_ADDR_W = 10;

	typedef logic [H_POS_W-1:0]   h_pos_t;	// horizontal pixel position
	typedef logic [V_POS_W-1:0]   v_pos_t;	// vertical pixel position
	typedef logic [COLOUR_W-1:0]  colour_t;	// one gun intensity
	typedef logic [DL_ADDR_W-1:0] dl_addr_t;	// table select in 9..8, entry in 7..0

	// ==============================
	// scroll register addresses
	// ==============================
	localparam logic [1:0] REG_HSCRL_LO = 2'd0;	// h scroll bits 7..0
	localparam logic [1:0] REG_HSCRL_HI = 2'd1;	// h scroll bit 8 from data bit 0
	localparam logic [1:0] REG_VSCRL    = 2'd2;
	localparam logic [1:0] REG_CTRL     = 2'd3;	// flip in data bit 0

	// ==============================
	// layer pixel code
	// ==============================
	// foreground tiles carry only two colour bits, sprites and background four
	typedef union packed {
		struct packed {
			logic [5:0] bank;
			logic [1:0] colour;
		} narrow;
		struct packed {
			logic [3:0] bank;
			logic [3:0] colour;
		} wide;
	} pixel_code_u;

	// ==============================
	// palette table selector
	// ==============================
	localparam logic [1:0] TABLE_RED   = 2'd0;
	localparam logic [1:0] TABLE_GREEN = 2'd1;
	localparam logic [1:0] TABLE_BLUE  = 2'd2;	// value 3 selects nothing
	localparam int         NUM_TABLES  = 3;
	localparam int         TABLE_DEPTH = 256;

endpackage

// File: hw/video_timing/video_timing.sv
// pixel and line counters with flip mapping, sync and blanking decode
`timescale 1ns/10ps

module video_timing
	import slap_video_pkg::*;
#(
	parameter int H_TOTAL      = 384,
	parameter int H_ACTIVE     = 256,
	parameter int H_SYNC_START = 296,
	parameter int H_SYNC_END   = 328,
	parameter int V_TOTAL      = 263,
	parameter int V_ACTIVE     = 224,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_END   = 243
) (
	input  logic   pixel_clk,
	input  logic   RESET_n,
	input  logic   flip_i,
	output h_pos_t h_pos_o,
	output v_pos_t v_pos_o,
	output logic   h_sync_o,
	output logic   h_blank_o,
	output logic   v_sync_o,
	output logic   v_blank_o
);

	localparam h_pos_t H_LAST = h_pos_t'(H_TOTAL - 1);
	localparam v_pos_t V_LAST = v_pos_t'(V_TOTAL - 1);

	h_pos_t h_cnt;	// pixel within the line
	v_pos_t v_cnt;	// line within the frame
	logic   line_end;

	assign line_end = (h_cnt == H_LAST);

	// ==============================
	// counters
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (line_end) begin
				h_cnt <= '0;
				// next line, wrap at bottom of frame
				if (v_cnt == V_LAST) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// ==============================
	// reported position
	// ==============================
	// flipped screen runs right to left and bottom to top
	always_comb begin
		if (flip_i) begin
			h_pos_o = H_LAST - h_cnt;
			v_pos_o = ~v_cnt;
		end else begin
			h_pos_o = h_cnt;
			v_pos_o = v_cnt;
		end
	end

	// ==============================
	// sync and blank windows
	// ==============================
	// taken from the raw counts so flip does not move them
	always_comb begin
		h_blank_o = (h_cnt >= h_pos_t'(H_ACTIVE));
		h_sync_o  = (h_cnt >= h_pos_t'(H_SYNC_START)) && (h_cnt < h_pos_t'(H_SYNC_END));
		v_blank_o = (v_cnt >= v_pos_t'(V_ACTIVE));
		v_sync_o  = (v_cnt >= v_pos_t'(V_SYNC_START)) && (v_cnt < v_pos_t'(V_SYNC_END));
	end

endmodule

// File: hw/scroll/scroll_regs.sv
// cpu write decode for horizontal scroll, vertical scroll and screen flip
`timescale 1ns/10ps

module scroll_regs
	import slap_video_pkg::*;
(
	input  logic       pixel_clk,
	input  logic       RESET_n,
	input  logic       reg_wr_i,
	input  logic [1:0] reg_addr_i,
	input  logic [7:0] reg_data_i,
	output h_pos_t     h_scroll_o,
	output v_pos_t     v_scroll_o,
	output logic       flip_o
);

	h_pos_t h_scroll;	// 9 bits written in two halves
	v_pos_t v_scroll;
	logic   flip;

	// ==============================
	// register writes
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_scroll <= '0;
			v_scroll <= '0;
			flip     <= 1'b0;
		end else if (reg_wr_i) begin
			case (reg_addr_i)
				REG_HSCRL_LO: begin
					h_scroll[7:0] <= reg_data_i;
				end
				REG_HSCRL_HI: begin
					h_scroll[8] <= reg_data_i[0];	// top bit only
				end
				REG_VSCRL: begin
					v_scroll <= reg_data_i;
				end
				REG_CTRL: begin
					flip <= reg_data_i[0];
				end
			endcase
		end
	end

	// new values show up the cycle after the strobe
	assign h_scroll_o = h_scroll;
	assign v_scroll_o = v_scroll;
	assign flip_o     = flip;

endmodule

// File: hw/scroll/scroll_adder.sv
// registered scroll offset adders giving background layer coordinates
`timescale 1ns/10ps

module scroll_adder
	import slap_video_pkg::*;
(
	input  logic   pixel_clk,
	input  logic   RESET_n,
	input  h_pos_t h_pos_i,
	input  v_pos_t v_pos_i,
	input  h_pos_t h_scroll_i,
	input  v_pos_t v_scroll_i,
	output h_pos_t bg_h_o,
	output v_pos_t bg_v_o
);

	h_pos_t h_sum;
	v_pos_t v_sum;

	// sums are truncated to the type width
	// so h wraps at 512 and v at 256
	always_comb begin
		h_sum = h_pos_i + h_scroll_i;
		v_sum = v_pos_i + v_scroll_i;
	end

	// ==============================
	// output stage
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bg_h_o <= '0;
			bg_v_o <= '0;
		end else begin
			bg_h_o <= h_sum;	// one pixel behind the position
			bg_v_o <= v_sum;
		end
	end

endmodule

// File: hw/layer_mixer.sv
// foreground over sprite over background priority select into a colour index
`timescale 1ns/10ps

module layer_mixer
	import slap_video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  pixel_code_u fg_pixel_i,
	input  pixel_code_u sp_pixel_i,
	input  pixel_code_u bg_pixel_i,
	output logic [7:0]  colour_index_o
);

	pixel_code_u winner;
	logic        fg_opaque;
	logic        sp_opaque;

	// colour 0 is see-through on the upper two layers
	assign fg_opaque = (fg_pixel_i.narrow.colour != 2'd0);
	assign sp_opaque = (sp_pixel_i.wide.colour != 4'd0);

	always_comb begin
		if (fg_opaque) begin
			winner = fg_pixel_i;
		end else if (sp_opaque) begin
			winner = sp_pixel_i;
		end else begin
			winner = bg_pixel_i;	// background is never transparent
		end
	end

	// ==============================
	// colour index register
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			colour_index_o <= 8'd0;
		end else begin
			colour_index_o <= winner;	// whole word, bank and colour
		end
	end

endmodule

// File: hw/palette_ram.sv
// downloadable red, green and blue colour tables with registered read
`timescale 1ns/10ps

module palette_ram
	import slap_video_pkg::*;
(
	input  logic       pixel_clk,
	input  logic       RESET_n,
	input  logic [7:0] colour_index_i,
	input  logic       dl_wr_i,
	input  dl_addr_t   dl_addr_i,
	input  logic [7:0] dl_data_i,
	output colour_t    red_o,
	output colour_t    green_o,
	output colour_t    blue_o
);

	colour_t    table_mem [NUM_TABLES][TABLE_DEPTH];
	logic [1:0] dl_sel;
	logic [7:0] dl_entry;
	logic       dl_hit;

	assign dl_sel   = dl_addr_i[9:8];
	assign dl_entry = dl_addr_i[7:0];
	assign dl_hit   = dl_wr_i && (dl_sel != 2'd3);	// fourth slot has no table

	// ==============================
	// download port
	// ==============================
	always_ff @(posedge pixel_clk) begin
		if (dl_hit) begin
			table_mem[dl_sel][dl_entry] <= dl_data_i[3:0];	// low nibble only
		end
	end

	// ==============================
	// pixel read
	// ==============================
	// all three guns looked up in parallel
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end else begin
			red_o   <= table_mem[TABLE_RED][colour_index_i];
			green_o <= table_mem[TABLE_GREEN][colour_index_i];
			blue_o  <= table_mem[TABLE_BLUE][colour_index_i];
		end
	end

endmodule

// File: hw/slap_video_top.sv
// video top level joining timing, scroll, mixer and palette blocks
`timescale 1ns/10ps

module slap_video_top
	import slap_video_pkg::*;
#(
	parameter int H_TOTAL      = 384,
	parameter int H_ACTIVE     = 256,
	parameter int H_SYNC_START = 296,
	parameter int H_SYNC_END   = 328,
	parameter int V_TOTAL      = 263,
	parameter int V_ACTIVE     = 224,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_END   = 243
) (
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  logic        reg_wr_i,
	input  logic [1:0]  reg_addr_i,
	input  logic [7:0]  reg_data_i,
	input  logic        dl_wr_i,
	input  dl_addr_t    dl_addr_i,
	input  logic [7:0]  dl_data_i,
	input  pixel_code_u fg_pixel_i,
	input  pixel_code_u sp_pixel_i,
	input  pixel_code_u bg_pixel_i,
	output h_pos_t      h_pos_o,
	output v_pos_t      v_pos_o,
	output h_pos_t      bg_h_o,
	output v_pos_t      bg_v_o,
	output logic        h_sync_o,
	output logic        h_blank_o,
	output logic        v_sync_o,
	output logic        v_blank_o,
	output colour_t     red_o,
	output colour_t     green_o,
	output colour_t     blue_o
);

	h_pos_t     h_scroll;
	v_pos_t     v_scroll;
	logic       flip;
	logic [7:0] colour_index;	// mixer to palette

	// ==============================
	// timing and scroll
	// ==============================
	video_timing #(
		.H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
		.V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
	) u_timing (
		.pixel_clk(pixel_clk), .RESET_n(RESET_n), .flip_i(flip),
		.h_pos_o(h_pos_o), .v_pos_o(v_pos_o),
		.h_sync_o(h_sync_o), .h_blank_o(h_blank_o),
		.v_sync_o(v_sync_o), .v_blank_o(v_blank_o)
	);

	scroll_regs u_regs (
		.pixel_clk(pixel_clk), .RESET_n(RESET_n),
		.reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
		.h_scroll_o(h_scroll), .v_scroll_o(v_scroll), .flip_o(flip)
	);

	scroll_adder u_adder (
		.pixel_clk(pixel_clk), .RESET_n(RESET_n),
		.h_pos_i(h_pos_o), .v_pos_i(v_pos_o),
		.h_scroll_i(h_scroll), .v_scroll_i(v_scroll),
		.bg_h_o(bg_h_o), .bg_v_o(bg_v_o)
	);

	// ==============================
	// colour path, 2 cycles
	// ==============================
	layer_mixer u_mixer (
		.pixel_clk(pixel_clk), .RESET_n(RESET_n),
		.fg_pixel_i(fg_pixel_i), .sp_pixel_i(sp_pixel_i), .bg_pixel_i(bg_pixel_i),
		.colour_index_o(colour_index)
	);

	palette_ram u_palette (
		.pixel_clk(pixel_clk), .RESET_n(RESET_n),
		.colour_index_i(colour_index),
		.dl_wr_i(dl_wr_i), .dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i),
		.red_o(red_o), .green_o(green_o), .blue_o(blue_o)
	);

endmodule

// File: testbench/tb_clock.sv
// testbench pixel clock generator and power-on reset
`timescale 1ns/10ps

module tb_clock #(
	parameter int RESET_CYCLES = 4
) (
	output logic pixel_clk_o,
	output logic RESET_n_o
);

	// 20 ns period
	initial begin
		pixel_clk_o = 1'b0;
		forever #10 pixel_clk_o = ~pixel_clk_o;
	end

	initial begin
		RESET_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge pixel_clk_o);
		#2;
		RESET_n_o = 1'b1;	// released off the edge
	end

endmodule

// File: testbench/tb_slap_video.sv
// directed tests for the video top level with lfsr data, checks and watchdog
`timescale 1ns/10ps

module tb_slap_video
	import slap_video_pkg::*;
();

	localparam int H_TOTAL = 40;
	localparam int H_ACTIVE = 24;
	localparam int H_SYNC_START = 28;
	localparam int H_SYNC_END = 32;
	localparam int V_TOTAL = 12;
	localparam int V_ACTIVE = 8;
	localparam int V_SYNC_START = 9;
	localparam int V_SYNC_END = 10;
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int NUM_PIXELS = 200;
	localparam int TIMING_CYCLES = 2 * FRAME + 2 * H_TOTAL;
	localparam int SCROLL_CYCLES = 3 * H_TOTAL;
	localparam int BUDGET = 8 + (TIMING_CYCLES + 1) + (3 + SCROLL_CYCLES) +
		(2 * FRAME + 4) + (NUM_TABLES * TABLE_DEPTH + NUM_PIXELS + 2);
	localparam int CYCLE_LIMIT = BUDGET + 100;	// margin

	logic        pixel_clk;
	logic        RESET_n;
	logic        reg_wr_i;
	logic [1:0]  reg_addr_i;
	logic [7:0]  reg_data_i;
	logic        dl_wr_i;
	dl_addr_t    dl_addr_i;
	logic [7:0]  dl_data_i;
	pixel_code_u fg_pixel_i;
	pixel_code_u sp_pixel_i;
	pixel_code_u bg_pixel_i;
	h_pos_t      h_pos_o;
	v_pos_t      v_pos_o;
	h_pos_t      bg_h_o;
	v_pos_t      bg_v_o;
	logic        h_sync_o;
	logic        h_blank_o;
	logic        v_sync_o;
	logic        v_blank_o;
	colour_t     red_o;
	colour_t     green_o;
	colour_t     blue_o;

	int          value_errs = 0;
	int          other_errs = 0;
	int          cycle_cnt = 0;
	logic [15:0] lfsr_state = 16'd84;

	tb_clock #(.RESET_CYCLES(4)) u_clock (.pixel_clk_o(pixel_clk), .RESET_n_o(RESET_n));

	slap_video_top #(
		.H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
		.V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_END(V_SYNC_END)
	) UUT (
		.pixel_clk(pixel_clk), .RESET_n(RESET_n),
		.reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i), .reg_data_i(reg_data_i),
		.dl_wr_i(dl_wr_i), .dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i),
		.fg_pixel_i(fg_pixel_i), .sp_pixel_i(sp_pixel_i), .bg_pixel_i(bg_pixel_i),
		.h_pos_o(h_pos_o), .v_pos_o(v_pos_o), .bg_h_o(bg_h_o), .bg_v_o(bg_v_o),
		.h_sync_o(h_sync_o), .h_blank_o(h_blank_o),
		.v_sync_o(v_sync_o), .v_blank_o(v_blank_o),
		.red_o(red_o), .green_o(green_o), .blue_o(blue_o)
	);

	// ==============================
	// helpers
	// ==============================
	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			value = {value[30:0], lfsr_state[15]};
			lfsr_state = {lfsr_state[14:0], fb};
		end
		return value;
	endfunction

	// foreground, then sprite, then background
	function automatic logic [7:0] pick_colour_index(input pixel_code_u fg,
		input pixel_code_u sp, input pixel_code_u bg);
		if (fg.narrow.colour != 2'd0) begin
			return fg;
		end else if (sp.wide.colour != 4'd0) begin
			return sp;
		end
		return bg;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp) else begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, got);
			value_errs++;
		end
	endtask

	task automatic step();
		@(posedge pixel_clk);
		#2;	// drive and sample off the edge
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		reg_wr_i = 1'b1;
		reg_addr_i = addr;
		reg_data_i = data;
		step();
		reg_wr_i = 1'b0;
	endtask

	task automatic check_idle();
		check_value("h_pos_o", 0, h_pos_o);
		check_value("v_pos_o", 0, v_pos_o);
		check_value("h_sync_o", 0, h_sync_o);
		check_value("v_sync_o", 0, v_sync_o);
		check_value("red_o", 0, red_o);
		check_value("green_o", 0, green_o);
		check_value("blue_o", 0, blue_o);
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic test_reset();
		repeat (2) begin
			@(negedge pixel_clk);
			check_idle();	// still in reset
		end
		wait (RESET_n === 1'b1);
		#1;
		check_idle();
	endtask

	task automatic test_timing();
		int     last_hs;
		int     hs_len;
		int     last_vs;
		int     vs_rises;
		int     blank_cnt;
		int     line;
		logic   prev_hs;
		logic   prev_vs;
		h_pos_t exp_h;
		last_hs = -1;
		hs_len = 0;
		last_vs = -1;
		vs_rises = 0;
		blank_cnt = -1;	// no full line seen yet
		line = 0;
		step();
		exp_h = 1;	// first edge out of reset
		check_value("h_pos_o", exp_h, h_pos_o);
		prev_hs = h_sync_o;
		prev_vs = v_sync_o;
		for (int cyc = 1; cyc <= TIMING_CYCLES; cyc++) begin
			step();
			if (exp_h == H_TOTAL - 1) begin
				exp_h = '0;
				line = (line == V_TOTAL - 1) ? 0 : line + 1;
			end else begin
				exp_h = exp_h + 1'b1;
			end
			check_value("h_pos_o", exp_h, h_pos_o);
			check_value("v_blank_o", line >= V_ACTIVE, v_blank_o);
			if (h_sync_o && !prev_hs) begin
				if (last_hs >= 0) begin
					check_value("h_sync_o period", H_TOTAL, cyc - last_hs);
				end
				last_hs = cyc;
				hs_len = 0;
			end
			if (h_sync_o) begin
				hs_len++;
			end
			if (!h_sync_o && prev_hs && last_hs >= 0) begin
				check_value("h_sync_o width", H_SYNC_END - H_SYNC_START, hs_len);
			end
			if (exp_h == 0) begin
				if (blank_cnt >= 0) begin
					check_value("h_blank_o cycles", H_TOTAL - H_ACTIVE, blank_cnt);
				end
				blank_cnt = 0;
			end
			if (h_blank_o && blank_cnt >= 0) begin
				blank_cnt++;
			end
			if (v_sync_o && !prev_vs) begin
				if (last_vs >= 0) begin
					check_value("v_sync_o period", FRAME, cyc - last_vs);
				end
				last_vs = cyc;
				vs_rises++;
			end
			prev_hs = h_sync_o;
			prev_vs = v_sync_o;
		end
		assert (vs_rises >= 2) else begin
			$display("v_sync_o did not rise twice within two frames");
			other_errs++;
		end
	endtask

	task automatic test_scroll();
		h_pos_t hs;
		v_pos_t vs;
		h_pos_t prev_h;
		v_pos_t prev_v;
		hs = 9'(lfsr_take(9));
		vs = 8'(lfsr_take(8));
		write_reg(REG_HSCRL_LO, hs[7:0]);
		write_reg(REG_HSCRL_HI, {7'(lfsr_take(7)), hs[8]});	// upper bits are noise
		write_reg(REG_VSCRL, vs);
		prev_h = h_pos_o;
		prev_v = v_pos_o;
		repeat (SCROLL_CYCLES) begin
			step();
			check_value("bg_h_o", (int'(prev_h) + int'(hs)) % 512, bg_h_o);
			check_value("bg_v_o", (int'(prev_v) + int'(vs)) % 256, bg_v_o);
			prev_h = h_pos_o;
			prev_v = v_pos_o;
		end
	endtask

	task automatic test_flip();
		logic   found;
		logic   prev_vs;
		int     line;
		h_pos_t exp_h;
		v_pos_t exp_v;
		found = 1'b0;
		prev_vs = v_sync_o;
		for (int waited = 0; waited <= FRAME && !found; waited++) begin
			step();
			found = v_sync_o && !prev_vs;
			prev_vs = v_sync_o;
		end
		assert (found) else begin
			$display("no v_sync_o rising edge found to start the flip test");
			other_errs++;
		end
		if (!found) begin
			return;
		end
		line = V_SYNC_START;	// sync rises at count 0 of this line
		write_reg(REG_CTRL, {7'(lfsr_take(7)), 1'b1});
		exp_h = H_TOTAL - 2;	// count has moved to 1
		for (int i = 0; i <= FRAME; i++) begin
			if (i > 0) begin
				step();
				if (exp_h == 0) begin
					exp_h = H_TOTAL - 1;
					line = (line == V_TOTAL - 1) ? 0 : line + 1;
				end else begin
					exp_h = exp_h - 1'b1;
				end
			end
			exp_v = ~v_pos_t'(line);
			check_value("h_pos_o", exp_h, h_pos_o);
			check_value("v_pos_o", exp_v, v_pos_o);
		end
		write_reg(REG_CTRL, 8'h00);
	endtask

	task automatic test_palette();
		colour_t     model [NUM_TABLES][TABLE_DEPTH];
		logic [7:0]  idx_q [$];
		logic [7:0]  idx;
		logic [7:0]  data;
		pixel_code_u fg;
		pixel_code_u sp;
		pixel_code_u bg;
		for (int t = 0; t < NUM_TABLES; t++) begin
			for (int e = 0; e < TABLE_DEPTH; e++) begin
				data = 8'(lfsr_take(8));
				model[t][e] = data[3:0];
				dl_wr_i = 1'b1;
				dl_addr_i = {t[1:0], e[7:0]};
				dl_data_i = data;
				step();
			end
		end
		dl_wr_i = 1'b0;
		// outputs at step i belong to the pixel driven at step i-2
		for (int i = 0; i < NUM_PIXELS + 2; i++) begin
			if (i >= 2) begin
				idx = idx_q.pop_front();
				check_value("red_o", model[TABLE_RED][idx], red_o);
				check_value("green_o", model[TABLE_GREEN][idx], green_o);
				check_value("blue_o", model[TABLE_BLUE][idx], blue_o);
			end
			if (i < NUM_PIXELS) begin
				fg = 8'(lfsr_take(8));
				sp = 8'(lfsr_take(8));
				bg = 8'(lfsr_take(8));
				if (lfsr_take(1) != 0) begin
					fg.narrow.colour = 2'd0;	// see-through
				end
				if (lfsr_take(1) != 0) begin
					sp.wide.colour = 4'd0;
				end
				fg_pixel_i = fg;
				sp_pixel_i = sp;
				bg_pixel_i = bg;
				idx_q.push_back(pick_colour_index(fg, sp, bg));
			end
			step();
		end
	endtask

	// ==============================
	// watchdog and main sequence
	// ==============================
	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge pixel_clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, tests did not finish", CYCLE_LIMIT);
		$display("sim failed");
		$finish;
	end

	initial begin
		reg_wr_i = 1'b0;
		reg_addr_i = 2'd0;
		reg_data_i = 8'd0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = 8'd0;
		fg_pixel_i = '0;
		sp_pixel_i = '0;
		bg_pixel_i = '0;
		test_reset();
		test_timing();
		test_scroll();
		test_flip();
		test_palette();
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: list.f
common/slap_video_pkg.sv
hw/video_timing/video_timing.sv
hw/scroll/scroll_regs.sv
hw/scroll/scroll_adder.sv
hw/layer_mixer.sv
hw/palette_ram.sv
hw/slap_video_top.sv
testbench/tb_clock.sv
testbench/tb_slap_video.sv

// File: Bender.yml
package:
  name: slap_video

sources:
  - common/slap_video_pkg.sv
  - hw/video_timing/video_timing.sv
  - hw/scroll/scroll_regs.sv
  - hw/scroll/scroll_adder.sv
  - hw/layer_mixer.sv
  - hw/palette_ram.sv
  - hw/slap_video_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_slap_video.sv
